//--- src/tomasuloPkg.sv
package tomasuloPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int tagWidth     = 4;

    // zero tag marks an operand whose value is present
    localparam logic [tagWidth-1:0] tagFree = '0;

    localparam logic [6:0] opcodeOp    = 7'b0110011;
    localparam logic [6:0] opcodeOpImm = 7'b0010011;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opSll,
        opSlt,
        opSltu,
        opXor,
        opSrl,
        opSra,
        opOr,
        opAnd
    } aluOpE;

    typedef struct packed {
        logic [6:0]              funct7;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rs1;
        logic [2:0]              funct3;
        logic [regAddrWidth-1:0] rd;
        logic [6:0]              opcode;
    } rTypeS;

    typedef struct packed {
        logic [11:0]             imm12;
        logic [regAddrWidth-1:0] rs1;
        logic [2:0]              funct3;
        logic [regAddrWidth-1:0] rd;
        logic [6:0]              opcode;
    } iTypeS;

    // same word, register form or immediate form
    typedef union packed {
        rTypeS rType;
        iTypeS iType;
    } instWordU;

    typedef struct packed {
        logic [tagWidth-1:0]  tag;
        logic [dataWidth-1:0] data;
    } operandS;

    typedef struct packed {
        logic                busy;
        aluOpE               op;
        logic [tagWidth-1:0] dest;
        operandS             src1;
        operandS             src2;
    } stationEntryS;

    typedef struct packed {
        aluOpE                   op;
        logic [regAddrWidth-1:0] rd;
        operandS                 src1;
        operandS                 src2;
    } issueS;

    typedef struct packed {
        logic                 valid;
        logic [tagWidth-1:0]  tag;
        logic [dataWidth-1:0] data;
    } cdbS;

endpackage

//--- src/instDispatch.sv
`timescale 1ns/100ps

module instDispatch import tomasuloPkg::*; (
    input  logic                    instValid,
    input  instWordU                inst,
    output logic                    stall,
    output logic [regAddrWidth-1:0] rs1Addr,
    output logic [regAddrWidth-1:0] rs2Addr,
    input  operandS                 op1,
    input  operandS                 op2,
    output logic                    renameValid,
    output logic [tagWidth-1:0]     renameTag,
    output issueS                   issue,
    output logic [1:0]              issueValid,
    input  logic [tagWidth-1:0]     freeTag0,
    input  logic [tagWidth-1:0]     freeTag1,
    input  logic [1:0]              hasFree
);

    logic    isOp;
    logic    isOpImm;
    logic    legal;
    logic    accept;
    logic    altBit;
    aluOpE   op;
    operandS immOperand;

    assign isOp    = inst.rType.opcode == opcodeOp;
    assign isOpImm = inst.iType.opcode == opcodeOpImm;
    assign legal   = isOp || isOpImm;

    // instruction bit 30, selects SUB and SRA/SRAI
    assign altBit = inst.rType.funct7[5];

    always_comb begin
        case (inst.rType.funct3)
            3'b000:  op = (isOp && altBit) ? opSub : opAdd;
            3'b001:  op = opSll;
            3'b010:  op = opSlt;
            3'b011:  op = opSltu;
            3'b100:  op = opXor;
            3'b101:  op = altBit ? opSra : opSrl;
            3'b110:  op = opOr;
            default: op = opAnd;
        endcase
    end

    // sign extended immediate is always present
    assign immOperand.tag  = tagFree;
    assign immOperand.data = {{(dataWidth-12){inst.iType.imm12[11]}}, inst.iType.imm12};

    assign rs1Addr = inst.rType.rs1;
    assign rs2Addr = inst.rType.rs2;

    assign stall = ~|hasFree;

    // other opcodes are consumed without effect
    assign accept = instValid && legal && !stall;

    // station 0 first, station 1 only when 0 is full
    assign issueValid[0] = accept && hasFree[0];
    assign issueValid[1] = accept && !hasFree[0];

    assign renameValid = accept && (inst.rType.rd != '0);
    assign renameTag   = hasFree[0] ? freeTag0 : freeTag1;

    assign issue.op   = op;
    assign issue.rd   = inst.rType.rd;
    assign issue.src1 = op1;
    assign issue.src2 = isOpImm ? immOperand : op2;

endmodule

//--- src/regStatus.sv
`timescale 1ns/100ps

module regStatus import tomasuloPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] rs1Addr,
    input  logic [regAddrWidth-1:0] rs2Addr,
    output operandS                 op1,
    output operandS                 op2,
    input  logic                    renameValid,
    input  logic [regAddrWidth-1:0] renameAddr,
    input  logic [tagWidth-1:0]     renameTag,
    input  cdbS                     cdb,
    input  logic [regAddrWidth-1:0] regRdAddr,
    output logic [dataWidth-1:0]    regRdData
);

    localparam int regCount = 1 << regAddrWidth;

    logic [dataWidth-1:0] regData [regCount];
    logic [tagWidth-1:0]  regTag  [regCount];

    // operand read with same-cycle bus bypass
    function automatic operandS readOperand(input logic [regAddrWidth-1:0] addr);
        operandS result;
        if (addr == '0) begin
            result.tag  = tagFree;
            result.data = '0;
        end else if (cdb.valid && regTag[addr] != tagFree && regTag[addr] == cdb.tag) begin
            result.tag  = tagFree;
            result.data = cdb.data;
        end else begin
            result.tag  = regTag[addr];
            result.data = regData[addr];
        end
        return result;
    endfunction

    always_comb begin
        op1 = readOperand(rs1Addr);
        op2 = readOperand(rs2Addr);
    end

    // x0 is held at zero, so no special case here
    assign regRdData = regData[regRdAddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regData[i] <= '0;
                regTag[i]  <= tagFree;
            end
        end else begin
            // write-back only to the register's latest producer
            for (int i = 1; i < regCount; i++) begin
                if (cdb.valid && regTag[i] != tagFree && regTag[i] == cdb.tag) begin
                    regData[i] <= cdb.data;
                    regTag[i]  <= tagFree;
                end
            end
            // rename overrides a write-back to the same register
            if (renameValid && renameAddr != '0) begin
                regTag[renameAddr] <= renameTag;
            end
        end
    end

endmodule

//--- src/aluStation.sv
`timescale 1ns/100ps

module aluStation import tomasuloPkg::*; #(
    parameter int stationId         = 0,
    parameter int entriesPerStation = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                issueValid,
    input  issueS               issue,
    output logic                hasFree,
    output logic [tagWidth-1:0] freeTag,
    input  cdbS                 cdb,
    output cdbS                 request,
    input  logic                grant
);

    localparam int idxWidth = (entriesPerStation > 1) ? $clog2(entriesPerStation) : 1;

    stationEntryS entries [entriesPerStation];

    // result registered, waiting for the bus
    logic [entriesPerStation-1:0] inFlight;

    logic [entriesPerStation-1:0] emptyVec;
    logic [entriesPerStation-1:0] readyVec;
    logic [entriesPerStation-1:0] freeSlot;
    logic [entriesPerStation-1:0] readySel;
    logic [idxWidth-1:0]          freeIdx;
    logic [idxWidth-1:0]          readyIdx;
    logic [idxWidth-1:0]          reqIdx;
    logic                         anyReady;
    stationEntryS                 selEntry;
    logic [dataWidth-1:0]         result;

    function automatic logic [dataWidth-1:0] execute(
        input aluOpE                op,
        input logic [dataWidth-1:0] a,
        input logic [dataWidth-1:0] b
    );
        logic [4:0]           shamt;
        logic [dataWidth-1:0] res;
        shamt = b[4:0];
        case (op)
            opAdd:   res = a + b;
            opSub:   res = a - b;
            opSll:   res = a << shamt;
            opSlt:   res = {{(dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
            opSltu:  res = {{(dataWidth-1){1'b0}}, a < b};
            opXor:   res = a ^ b;
            opSrl:   res = a >> shamt;
            opSra:   res = $signed(a) >>> shamt;
            opOr:    res = a | b;
            opAnd:   res = a & b;
            default: res = '0;
        endcase
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < entriesPerStation; i++) begin
            emptyVec[i] = !entries[i].busy;
            readyVec[i] = entries[i].busy && !inFlight[i]
                && entries[i].src1.tag == tagFree
                && entries[i].src2.tag == tagFree;
        end
    end

    // lowest set bit
    assign freeSlot = emptyVec & (-emptyVec);
    assign readySel = readyVec & (-readyVec);

    assign hasFree  = |emptyVec;
    assign anyReady = |readyVec;

    // one-hot to index
    always_comb begin
        freeIdx  = '0;
        readyIdx = '0;
        for (int i = 0; i < entriesPerStation; i++) begin
            if (freeSlot[i]) begin
                freeIdx = idxWidth'(i);
            end
            if (readySel[i]) begin
                readyIdx = idxWidth'(i);
            end
        end
    end

    assign freeTag = tagWidth'(1 + stationId * entriesPerStation + int'(freeIdx));

    assign selEntry = entries[readyIdx];
    assign result   = execute(selEntry.op, selEntry.src1.data, selEntry.src2.data);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < entriesPerStation; i++) begin
                entries[i].busy <= 1'b0;
            end
            inFlight      <= '0;
            request.valid <= 1'b0;
        end else begin
            // wakeup of waiting operands from the bus
            for (int i = 0; i < entriesPerStation; i++) begin
                if (entries[i].busy && cdb.valid) begin
                    if (entries[i].src1.tag != tagFree && entries[i].src1.tag == cdb.tag) begin
                        entries[i].src1.tag  <= tagFree;
                        entries[i].src1.data <= cdb.data;
                    end
                    if (entries[i].src2.tag != tagFree && entries[i].src2.tag == cdb.tag) begin
                        entries[i].src2.tag  <= tagFree;
                        entries[i].src2.data <= cdb.data;
                    end
                end
            end

            if (issueValid) begin
                entries[freeIdx] <= '{
                    busy: 1'b1,
                    op:   issue.op,
                    dest: freeTag,
                    src1: issue.src1,
                    src2: issue.src2
                };
            end

            // entry is released only once its beat is on the bus
            if (grant) begin
                entries[reqIdx].busy <= 1'b0;
                inFlight[reqIdx]     <= 1'b0;
            end

            if (!request.valid || grant) begin
                request.valid <= anyReady;
                if (anyReady) begin
                    request.tag        <= selEntry.dest;
                    request.data       <= result;
                    reqIdx             <= readyIdx;
                    inFlight[readyIdx] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- src/cdbArbiter.sv
`timescale 1ns/100ps

module cdbArbiter import tomasuloPkg::*; (
    input  logic clk,
    input  logic rst,
    input  cdbS  request0,
    input  cdbS  request1,
    output logic grant0,
    output logic grant1,
    output cdbS  cdb
);

    // set when station 1 wins the next tie
    logic favorOne;

    assign grant0 = request0.valid && (!request1.valid || !favorOne);
    assign grant1 = request1.valid && (!request0.valid || favorOne);

    always_comb begin
        if (grant0) begin
            cdb = request0;
        end else if (grant1) begin
            cdb = request1;
        end else begin
            cdb = '0;
        end
    end

    // flip only on contention
    always_ff @(posedge clk) begin
        if (rst) begin
            favorOne <= 1'b0;
        end else if (request0.valid && request1.valid) begin
            favorOne <= !favorOne;
        end
    end

endmodule

//--- src/tomasuloCore.sv
`timescale 1ns/100ps

module tomasuloCore import tomasuloPkg::*; #(
    parameter int entriesPerStation = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instValid,
    input  instWordU                inst,
    output logic                    stall,
    output cdbS                     cdb,
    input  logic [regAddrWidth-1:0] regRdAddr,
    output logic [dataWidth-1:0]    regRdData
);

    logic [regAddrWidth-1:0] rs1Addr;
    logic [regAddrWidth-1:0] rs2Addr;
    operandS                 op1;
    operandS                 op2;
    logic                    renameValid;
    logic [tagWidth-1:0]     renameTag;
    issueS                   issue;
    logic [1:0]              issueValid;
    logic [tagWidth-1:0]     freeTag0;
    logic [tagWidth-1:0]     freeTag1;
    logic [1:0]              hasFree;
    cdbS                     request0;
    cdbS                     request1;
    logic                    grant0;
    logic                    grant1;

    instDispatch u_instDispatch (
        .instValid   (instValid),
        .inst        (inst),
        .stall       (stall),
        .rs1Addr     (rs1Addr),
        .rs2Addr     (rs2Addr),
        .op1         (op1),
        .op2         (op2),
        .renameValid (renameValid),
        .renameTag   (renameTag),
        .issue       (issue),
        .issueValid  (issueValid),
        .freeTag0    (freeTag0),
        .freeTag1    (freeTag1),
        .hasFree     (hasFree)
    );

    // rename target is the destination carried in the issue
    regStatus u_regStatus (
        .clk         (clk),
        .rst         (rst),
        .rs1Addr     (rs1Addr),
        .rs2Addr     (rs2Addr),
        .op1         (op1),
        .op2         (op2),
        .renameValid (renameValid),
        .renameAddr  (issue.rd),
        .renameTag   (renameTag),
        .cdb         (cdb),
        .regRdAddr   (regRdAddr),
        .regRdData   (regRdData)
    );

    aluStation #(
        .stationId         (0),
        .entriesPerStation (entriesPerStation)
    ) u_aluStation0 (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid[0]),
        .issue      (issue),
        .hasFree    (hasFree[0]),
        .freeTag    (freeTag0),
        .cdb        (cdb),
        .request    (request0),
        .grant      (grant0)
    );

    aluStation #(
        .stationId         (1),
        .entriesPerStation (entriesPerStation)
    ) u_aluStation1 (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid[1]),
        .issue      (issue),
        .hasFree    (hasFree[1]),
        .freeTag    (freeTag1),
        .cdb        (cdb),
        .request    (request1),
        .grant      (grant1)
    );

    cdbArbiter u_cdbArbiter (
        .clk      (clk),
        .rst      (rst),
        .request0 (request0),
        .request1 (request1),
        .grant0   (grant0),
        .grant1   (grant1),
        .cdb      (cdb)
    );

endmodule

//--- tests/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
    parameter int halfPeriod  = 4,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tests/coreTb.sv
`timescale 1ns/100ps

module coreTb import tomasuloPkg::*; ();

    localparam int stationDepth  = 4;
    localparam int slotCount     = 2 * stationDepth;
    localparam int randomCount   = 200;
    localparam int totalInsts    = 8 + 8 + 16 + randomCount;
    localparam int timeoutCycles = totalInsts * 20 + 200;

    logic                    clk;
    logic                    rst;
    logic                    instValid;
    instWordU                inst;
    logic                    stall;
    cdbS                     cdb;
    logic [regAddrWidth-1:0] regRdAddr;
    logic [dataWidth-1:0]    regRdData;

    // model state in program order
    logic [dataWidth-1:0] modelRegs [32];
    logic [dataWidth-1:0] instResult;
    logic [dataWidth-1:0] expData [16];
    logic [dataWidth-1:0] expectedReg;
    // one bit per tag, set from issue until its bus beat
    logic [15:0]          occupied;
    logic                 seenAccept;
    logic                 stallSeen;
    logic                 regCheckActive;
    logic                 burstCheck;
    logic                 endCheck;
    int                   acceptedCount;
    int                   beatCount;
    int                   errorCount;

    clockGen u_clockGen (
        .clk (clk),
        .rst (rst)
    );

    tomasuloCore #(
        .entriesPerStation (stationDepth)
    ) u_tomasuloCore (
        .clk       (clk),
        .rst       (rst),
        .instValid (instValid),
        .inst      (inst),
        .stall     (stall),
        .cdb       (cdb),
        .regRdAddr (regRdAddr),
        .regRdData (regRdData)
    );

    function automatic instWordU buildRType(input logic [6:0] funct7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] funct3,
                                            input logic [4:0] rd);
        instWordU w;
        w.rType = '{funct7, rs2, rs1, funct3, rd, opcodeOp};
        return w;
    endfunction

    function automatic instWordU buildIType(input logic [11:0] imm12, input logic [4:0] rs1,
                                            input logic [2:0] funct3, input logic [4:0] rd);
        instWordU w;
        w.iType = '{imm12, rs1, funct3, rd, opcodeOpImm};
        return w;
    endfunction

    // registers x0 to x7 only, so dependences are dense
    function automatic instWordU randomInst();
        logic [2:0] funct3;
        logic       alt;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        instWordU   w;
        funct3 = 3'($urandom_range(0, 7));
        alt    = 1'($urandom_range(0, 1));
        rd     = 5'($urandom_range(0, 7));
        rs1    = 5'($urandom_range(0, 7));
        rs2    = 5'($urandom_range(0, 7));
        if ($urandom_range(0, 1) == 0) begin
            // only sub and sra use bit 30 in the register form
            w = buildRType((alt && (funct3 == 3'd0 || funct3 == 3'd5)) ? 7'b0100000 : 7'b0,
                           rs2, rs1, funct3, rd);
        end else if (funct3 == 3'd1 || funct3 == 3'd5) begin
            w = buildIType({(alt && funct3 == 3'd5) ? 7'b0100000 : 7'b0,
                            5'($urandom_range(0, 31))}, rs1, funct3, rd);
        end else begin
            w = buildIType(12'($urandom), rs1, funct3, rd);
        end
        return w;
    endfunction

    // RV32I result from the current model registers
    function automatic logic [dataWidth-1:0] computeExpected(input instWordU w);
        logic                 isReg;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [4:0]           shamt;
        logic [dataWidth-1:0] res;
        isReg = w.rType.opcode == opcodeOp;
        a     = modelRegs[w.rType.rs1];
        b     = isReg ? modelRegs[w.rType.rs2] : {{20{w.iType.imm12[11]}}, w.iType.imm12};
        shamt = b[4:0];
        case (w.rType.funct3)
            3'd0: res = (isReg && w.rType.funct7[5]) ? a - b : a + b;
            3'd1: res = a << shamt;
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (w.rType.funct7[5]) res = $signed(a) >>> shamt;
                else res = a >> shamt;
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // station 0 first, lowest empty entry within a station
    function automatic logic [tagWidth-1:0] pickTag(input logic [15:0] busyTags);
        logic [tagWidth-1:0] tag;
        tag = tagFree;
        for (int i = 1; i <= slotCount; i++) begin
            if (tag == tagFree && !busyTags[i]) tag = tagWidth'(i);
        end
        return tag;
    endfunction

    task automatic reportFailure(input string msg);
        errorCount++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task automatic sendInst(input instWordU w);
        logic                 accepted;
        logic [dataWidth-1:0] result;
        result = computeExpected(w);
        inst       <= w;
        instValid  <= 1'b1;
        instResult <= result;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = !stall;
            @(posedge clk);
        end
        if (w.rType.rd != 5'd0) modelRegs[w.rType.rd] = result;
    endtask

    task automatic idleCycles(input int count);
        instValid <= 1'b0;
        repeat (count) @(posedge clk);
    endtask

    task automatic checkRegisters(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            regRdAddr      <= regAddrWidth'(i);
            expectedReg    <= modelRegs[i];
            regCheckActive <= 1'b1;
            @(posedge clk);
        end
        regCheckActive <= 1'b0;
        regRdAddr      <= '0;
        @(posedge clk);
    endtask

    always @(posedge clk) begin : trackSlots
        logic [15:0]         nextBusy;
        logic [tagWidth-1:0] newTag;
        nextBusy = occupied;
        newTag   = pickTag(occupied);
        if (rst) begin
            occupied      <= '0;
            seenAccept    <= 1'b0;
            stallSeen     <= 1'b0;
            acceptedCount <= 0;
            beatCount     <= 0;
        end else begin
            // a beat frees its slot at the grant edge
            if (cdb.valid) begin
                nextBusy[cdb.tag] = 1'b0;
                beatCount <= beatCount + 1;
            end
            if (instValid && !stall) begin
                nextBusy[newTag] = 1'b1;
                expData[newTag] <= instResult;
                seenAccept      <= 1'b1;
                acceptedCount   <= acceptedCount + 1;
            end
            if (stall) stallSeen <= 1'b1;
            occupied <= nextBusy;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !seenAccept |-> (!stall && !cdb.valid))
        else reportFailure("stall or bus valid high before the first accepted instruction");

    assert property (@(posedge clk) disable iff (rst) regCheckActive |-> regRdData == expectedReg)
        else reportFailure($sformatf("x%0d reads %h, expected %h", $sampled(regRdAddr),
                                     $sampled(regRdData), $sampled(expectedReg)));

    assert property (@(posedge clk) disable iff (rst) regRdAddr == '0 |-> regRdData == '0)
        else reportFailure($sformatf("x0 reads %h", $sampled(regRdData)));

    assert property (@(posedge clk) disable iff (rst) stall == (&occupied[slotCount:1]))
        else reportFailure($sformatf("stall is %b with busy tags %b", $sampled(stall),
                                     $sampled(occupied[slotCount:1])));

    assert property (@(posedge clk) disable iff (rst)
                     cdb.valid |-> (cdb.tag != tagFree && occupied[cdb.tag]))
        else reportFailure($sformatf("bus tag %0d is not outstanding", $sampled(cdb.tag)));

    assert property (@(posedge clk) disable iff (rst) cdb.valid |-> cdb.data == expData[cdb.tag])
        else reportFailure($sformatf("bus tag %0d carries %h, expected %h", $sampled(cdb.tag),
                                     $sampled(cdb.data), expData[$sampled(cdb.tag)]));

    assert property (@(posedge clk) burstCheck |-> stallSeen)
        else reportFailure("stall never rose while the stations were full");

    assert property (@(posedge clk) endCheck |-> beatCount == acceptedCount)
        else reportFailure($sformatf("%0d instructions accepted but %0d bus beats",
                                     $sampled(acceptedCount), $sampled(beatCount)));

    initial begin
        void'($urandom(29863));
        instValid      = 1'b0;
        inst           = '0;
        instResult     = '0;
        regRdAddr      = '0;
        expectedReg    = '0;
        regCheckActive = 1'b0;
        burstCheck     = 1'b0;
        endCheck       = 1'b0;
        errorCount     = 0;
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        do @(posedge clk); while (rst);

        // chain, each step reads the previous destination
        sendInst(buildIType(12'h5a5, 5'd0, 3'd0, 5'd1));
        sendInst(buildIType(12'd7, 5'd1, 3'd1, 5'd2));
        sendInst(buildRType(7'b0100000, 5'd1, 5'd2, 3'd0, 5'd3));
        sendInst(buildIType(12'hccd, 5'd3, 3'd4, 5'd4));
        sendInst(buildIType(12'h403, 5'd4, 3'd5, 5'd5));
        sendInst(buildRType(7'b0, 5'd1, 5'd5, 3'd2, 5'd6));
        sendInst(buildRType(7'b0, 5'd4, 5'd6, 3'd6, 5'd7));
        sendInst(buildRType(7'b0, 5'd6, 5'd7, 3'd5, 5'd3));
        idleCycles(40);
        checkRegisters(3, 3);

        // slow producer of x1, then a burst that only waits on it
        for (int i = 0; i < 8; i++) sendInst(buildIType(12'(3 + i), 5'd1, 3'd0, 5'd1));
        for (int i = 0; i < 16; i++) begin
            sendInst(buildRType(7'b0, 5'd1, 5'd1, 3'(i % 8), 5'(2 + i % 6)));
        end
        idleCycles(40);
        burstCheck <= 1'b1;
        @(posedge clk);
        burstCheck <= 1'b0;

        for (int n = 0; n < randomCount; n++) begin
            if ($urandom_range(0, 7) == 0) idleCycles(1);
            sendInst(randomInst());
        end
        idleCycles(40);
        checkRegisters(0, 31);
        endCheck <= 1'b1;
        @(posedge clk);
        endCheck <= 1'b0;
        repeat (2) @(posedge clk);

        $display("accepted %0d, bus beats %0d, errors %0d", acceptedCount, beatCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- vlog.f
src/tomasuloPkg.sv
src/instDispatch.sv
src/regStatus.sv
src/aluStation.sv
src/cdbArbiter.sv
src/tomasuloCore.sv
tests/clockGen.sv
tests/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module coreTb -f vlog.f
output="$(./obj_dir/VcoreTb)"
echo "$output"
grep -q "All tests passed" <<< "$output"
